/* hw/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data and address width
`define MEM_XLEN 32

// decode lanes between issue and drain, 1 to 4
`define MEM_LANES 2

// round-robin pointer width, never below one bit
`define MEM_PTR_W ((`MEM_LANES > 1) ? $clog2(`MEM_LANES) : 1)

// control word fields
`define MEM_TYPE_LSB 0
`define MEM_TYPE_MSB 3
`define MEM_SUBTYPE_LSB 7
`define MEM_SUBTYPE_MSB 11
`define MEM_WRITE_BIT 5
`define MEM_READ_BIT 4
`define MEM_CACOP_MMU_BIT 28

`endif

/* hw/mem_pkg.sv */
`include "mem_defs.svh"

package mem_pkg;

    typedef logic [`MEM_XLEN-1:0]   word_t;      // data or address
    typedef logic [`MEM_XLEN/8-1:0] strb_t;      // one bit per byte
    typedef logic [1:0]             size_t;      // 0 byte, 1 half, 2 word
    typedef logic [15:0]            cacop_arg_t;

    // control word type field
    typedef enum logic [3:0] {
        OP_OTHER   = 4'd0,
        OP_MEM     = 4'd5,
        OP_ATOMIC  = 4'd6,
        OP_BARRIER = 4'd9
    } op_type_e;

    // decoded operation as it enters the stage
    typedef struct packed {
        word_t      ctrl;
        word_t      base;
        word_t      imm;
        word_t      wdata;      // store data, unshifted
        cacop_arg_t cacop_arg;
    } mem_op_t;

    // one request toward the data-cache port
    typedef struct packed {
        word_t addr;
        word_t wdata;           // already in its byte lanes
        logic  write;
        strb_t wstrb;
        size_t size;
        word_t opcode;          // cache maintenance code
        logic  icache_op;
        logic  dcache_op;
        logic  l2_op;
        logic  mmu_valid;
        logic  ibar;
        logic  ale;             // alignment fault
    } cache_req_t;

endpackage

/* hw/mem_issue.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_issue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  mem_pkg::mem_op_t      in_op,
    output logic                  in_ready,
    input  logic [`MEM_LANES-1:0] lane_full,
    output logic [`MEM_LANES-1:0] lane_load,
    output mem_pkg::mem_op_t      lane_op
);

    logic [`MEM_PTR_W-1:0] wr_ptr;
    logic                  accept;

    // only the lane under the pointer may take the next op
    assign in_ready = ~lane_full[wr_ptr];
    assign accept   = in_valid & in_ready;
    assign lane_op  = in_op; // shared, qualified by lane_load

    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            lane_load[i] = accept && (int'(wr_ptr) == i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (accept) begin
            if (int'(wr_ptr) == `MEM_LANES - 1) begin
                wr_ptr <= '0; // wrap
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // the lane being loaded must have been drained before
    a_load_empty_lane: assert property (
        @(posedge clk) disable iff (reset)
        (lane_load & lane_full) == '0
    );

endmodule

/* hw/cache_ctr.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module cache_ctr (
    input  logic                clk,
    input  logic                reset,
    input  logic                load,
    input  mem_pkg::mem_op_t    op,
    input  logic                pop,
    output logic                full,
    output mem_pkg::cache_req_t req
);
    import mem_pkg::*;

    mem_op_t  op_q;
    word_t    addr;
    op_type_e op_type;
    logic [4:0] subtype;
    logic     acc;       // plain load or store
    logic     st;
    size_t    acc_size;
    logic     misalign;
    word_t    st_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (pop) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_q <= op;
        end
    end

    assign addr    = op_q.base + op_q.imm;
    assign op_type = op_type_e'(op_q.ctrl[`MEM_TYPE_MSB:`MEM_TYPE_LSB]);
    assign subtype = op_q.ctrl[`MEM_SUBTYPE_MSB:`MEM_SUBTYPE_LSB];

    // classify the held op
    always_comb begin
        acc      = 1'b0;
        st       = 1'b0;
        acc_size = 2'd0;
        case (op_type)
            OP_MEM: begin
                case (subtype)
                    5'd0, 5'd6: acc = 1'b1;
                    5'd1, 5'd7: begin
                        acc      = 1'b1;
                        acc_size = 2'd1;
                    end
                    5'd2: begin
                        acc      = 1'b1;
                        acc_size = 2'd2;
                    end
                    5'd3: begin
                        acc = 1'b1;
                        st  = 1'b1;
                    end
                    5'd4: begin
                        acc      = 1'b1;
                        st       = 1'b1;
                        acc_size = 2'd1;
                    end
                    5'd5: begin
                        acc      = 1'b1;
                        st       = 1'b1;
                        acc_size = 2'd2;
                    end
                    default: ;
                endcase
            end
            OP_ATOMIC: begin
                if (subtype == 5'd11 || subtype == 5'd12) begin
                    acc      = 1'b1;
                    st       = (subtype == 5'd12);
                    acc_size = 2'd2;
                end
            end
            default: ;
        endcase
    end

    assign misalign = ((acc_size == 2'd1) && addr[0]) ||
                      ((acc_size == 2'd2) && (addr[1:0] != 2'b00));

    always_comb begin
        case (acc_size)
            2'd0:    st_data = word_t'(op_q.wdata[7:0]);
            2'd1:    st_data = word_t'(op_q.wdata[15:0]);
            default: st_data = op_q.wdata;
        endcase
    end

    // format the request
    always_comb begin
        req           = '0;
        req.addr      = addr;
        req.write     = op_q.ctrl[`MEM_WRITE_BIT];
        req.mmu_valid = op_q.ctrl[`MEM_WRITE_BIT] | op_q.ctrl[`MEM_READ_BIT] |
                        (op_q.ctrl[`MEM_CACOP_MMU_BIT] & (op_q.cacop_arg[4:3] == 2'd2));
        if (acc) begin
            req.size = acc_size;
            if (misalign) begin
                req.ale = 1'b1; // no strobes, no data
            end else begin
                case (acc_size)
                    2'd0:    req.wstrb = strb_t'(4'b0001 << addr[1:0]);
                    2'd1:    req.wstrb = addr[1] ? 4'b1100 : 4'b0011;
                    default: req.wstrb = 4'b1111;
                endcase
                if (st) begin
                    req.wdata = st_data << {addr[1:0], 3'b000};
                end
            end
        end else if (op_type == OP_MEM && subtype == 5'd8) begin
            case (op_q.cacop_arg[2:0])
                3'd0:    req.icache_op = 1'b1;
                3'd1:    req.dcache_op = 1'b1;
                3'd2:    req.l2_op     = 1'b1;
                default: ; // no target
            endcase
            req.opcode = word_t'(op_q.cacop_arg);
            req.ibar   = 1'b1;
        end else if (op_type == OP_BARRIER) begin
            req.opcode    = {1'b1, 31'b0};
            req.icache_op = 1'b1;
            req.ibar      = 1'b1;
        end
    end

    a_one_target: assert property (
        @(posedge clk) disable iff (reset)
        full |-> $onehot0({req.icache_op, req.dcache_op, req.l2_op})
    );

    a_ale_no_strobe: assert property (
        @(posedge clk) disable iff (reset)
        (full && req.ale) |-> (req.wstrb == '0)
    );

    // drain only takes from an occupied lane
    a_pop_when_full: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> full
    );

endmodule

/* hw/mem_drain.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_drain (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [`MEM_LANES-1:0]                   lane_full,
    input  mem_pkg::cache_req_t [`MEM_LANES-1:0]    lane_req,
    output logic [`MEM_LANES-1:0]                   lane_pop,
    output logic                                    req_valid,
    output mem_pkg::cache_req_t                     req,
    input  logic                                    req_ready
);

    logic [`MEM_PTR_W-1:0] rd_ptr;
    logic                  slot_free;
    logic                  take;

    // slot is empty or leaves this cycle
    assign slot_free = ~req_valid | req_ready;
    assign take      = lane_full[rd_ptr] & slot_free;

    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            lane_pop[i] = take && (int'(rd_ptr) == i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
            rd_ptr    <= '0;
        end else if (take) begin
            req_valid <= 1'b1;
            if (int'(rd_ptr) == `MEM_LANES - 1) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req <= lane_req[rd_ptr];
        end
    end

    // cache port sees a steady request until it accepts
    a_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        (req_valid && !req_ready) |=> (req_valid && $stable(req))
    );

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  mem_pkg::mem_op_t    in_op,
    output logic                in_ready,
    output logic                req_valid,
    output mem_pkg::cache_req_t req,
    input  logic                req_ready
);
    import mem_pkg::*;

    logic [`MEM_LANES-1:0]       lane_load;
    logic [`MEM_LANES-1:0]       lane_full;
    logic [`MEM_LANES-1:0]       lane_pop;
    mem_op_t                     lane_op;
    cache_req_t [`MEM_LANES-1:0] lane_req;

    mem_issue u_issue (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_ready  (in_ready),
        .lane_full (lane_full),
        .lane_load (lane_load),
        .lane_op   (lane_op)
    );

    for (genvar i = 0; i < `MEM_LANES; i++) begin : g_lane
        cache_ctr u_lane (
            .clk   (clk),
            .reset (reset),
            .load  (lane_load[i]),
            .op    (lane_op),
            .pop   (lane_pop[i]),
            .full  (lane_full[i]),
            .req   (lane_req[i])
        );
    end

    mem_drain u_drain (
        .clk       (clk),
        .reset     (reset),
        .lane_full (lane_full),
        .lane_req  (lane_req),
        .lane_pop  (lane_pop),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready)
    );

endmodule

/* dv/mem_stage_tb.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_stage_tb;
    import mem_pkg::*;

    localparam int N_ALIGNED      = 32;
    localparam int N_MISALIGN     = 24;
    localparam int N_CACHE        = 24;
    localparam int N_ANY          = 24;
    localparam int N_RANDOM       = 400;
    localparam int TOTAL_OPS      = N_ALIGNED + N_MISALIGN + N_CACHE + N_ANY + N_RANDOM;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_OPS + 200;
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    logic       clk = 1'b0;
    logic       reset;
    logic       in_valid;
    mem_op_t    in_op;
    logic       in_ready;
    logic       req_valid;
    cache_req_t req;
    logic       req_ready;

    logic [31:0] lfsr = 32'h5e0e_12f3;
    logic        ready_gaps = 1'b0;
    cache_req_t  expect_q[$];
    cache_req_t  exp_req;
    int          cycle_count  = 0;
    int          field_errors = 0;
    int          flow_errors  = 0;
    int          in_count     = 0;
    int          out_count    = 0;

    always #50 clk = ~clk;

    mem_stage u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_ready  (in_ready),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready)
    );

    // galois shift, one step per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? LFSR_POLY : 32'h0);
            v    = {v[30:0], b};
        end
        return v;
    endfunction

    // expected request, straight from the decode rules
    function automatic cache_req_t decode_ref(input mem_op_t op);
        cache_req_t  r;
        logic [31:0] a;
        logic [3:0]  kind;
        logic [4:0]  sub;
        logic        is_acc;
        logic        is_store;
        logic [1:0]  size_code;
        logic [1:0]  low_mask;
        logic [3:0]  lanes;
        logic [31:0] keep;
        r           = '0;
        a           = op.base + op.imm;
        kind        = op.ctrl[3:0];
        sub         = op.ctrl[11:7];
        is_acc      = 1'b0;
        is_store    = 1'b0;
        size_code   = 2'd0;
        r.addr      = a;
        r.write     = op.ctrl[5];
        r.mmu_valid = op.ctrl[5] | op.ctrl[4] | (op.ctrl[28] & (op.cacop_arg[4:3] == 2'b10));
        if (kind == 4'd5 && sub <= 5'd7) begin
            is_acc   = 1'b1;
            is_store = (sub >= 5'd3) && (sub <= 5'd5);
            case (sub)
                5'd0, 5'd3, 5'd6: size_code = 2'd0;
                5'd1, 5'd4, 5'd7: size_code = 2'd1;
                default:          size_code = 2'd2;
            endcase
        end else if (kind == 4'd6 && (sub == 5'd11 || sub == 5'd12)) begin
            is_acc    = 1'b1;
            is_store  = (sub == 5'd12);
            size_code = 2'd2;
        end
        if (is_acc) begin
            case (size_code)
                2'd0: begin
                    low_mask = 2'b00;
                    lanes    = 4'b0001;
                    keep     = 32'h0000_00ff;
                end
                2'd1: begin
                    low_mask = 2'b01;
                    lanes    = 4'b0011;
                    keep     = 32'h0000_ffff;
                end
                default: begin
                    low_mask = 2'b11;
                    lanes    = 4'b1111;
                    keep     = 32'hffff_ffff;
                end
            endcase
            r.size = size_code;
            if ((a[1:0] & low_mask) != 2'b00) begin
                r.ale = 1'b1; // misaligned halfword or word
            end else begin
                r.wstrb = lanes << a[1:0];
                if (is_store) begin
                    r.wdata = (op.wdata & keep) << {a[1:0], 3'b000};
                end
            end
        end else if (kind == 4'd5 && sub == 5'd8) begin
            r.icache_op = (op.cacop_arg[2:0] == 3'd0);
            r.dcache_op = (op.cacop_arg[2:0] == 3'd1);
            r.l2_op     = (op.cacop_arg[2:0] == 3'd2);
            r.opcode    = {16'h0000, op.cacop_arg};
            r.ibar      = 1'b1;
        end else if (kind == 4'd9) begin
            r.opcode    = 32'h8000_0000;
            r.icache_op = 1'b1;
            r.ibar      = 1'b1;
        end
        return r;
    endfunction

    // class 0 aligned access, 1 any alignment, 2 cacop/barrier/atomic, 3 raw
    function automatic mem_op_t make_op(input int cls, input logic [4:0] pick);
        mem_op_t     op;
        logic [31:0] sum;
        op.ctrl      = rand_bits(32);
        op.base      = rand_bits(32);
        op.imm       = rand_bits(32);
        op.wdata     = rand_bits(32);
        op.cacop_arg = 16'(rand_bits(16));
        if (cls == 0) begin
            op.ctrl[3:0]  = 4'd5;
            op.ctrl[11:7] = {2'b00, pick[2:0]};
            sum = op.base + op.imm;
            if (pick[2:0] == 3'd2 || pick[2:0] == 3'd5) begin
                op.base = op.base - {30'b0, sum[1:0]};
            end else if (pick[2:0] == 3'd1 || pick[2:0] == 3'd4 || pick[2:0] == 3'd7) begin
                op.base = op.base - {31'b0, sum[0]};
            end
        end else if (cls == 1) begin
            if (rand_bits(2) == 32'd0) begin
                op.ctrl[3:0]  = 4'd6;
                op.ctrl[11:7] = (rand_bits(1) != 32'd0) ? 5'd12 : 5'd11;
            end else begin
                op.ctrl[3:0]  = 4'd5;
                op.ctrl[11:7] = 5'(rand_bits(3));
            end
        end else if (cls == 2) begin
            case (rand_bits(2))
                32'd0, 32'd1: begin
                    op.ctrl[3:0]  = 4'd5;
                    op.ctrl[11:7] = 5'd8;
                end
                32'd2: op.ctrl[3:0] = 4'd9;
                default: begin
                    op.ctrl[3:0]  = 4'd6;
                    op.ctrl[11:7] = (rand_bits(1) != 32'd0) ? 5'd12 : 5'd11;
                end
            endcase
        end
        return op;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        if (ready_gaps) begin
            req_ready = (rand_bits(2) != 32'd0);
        end else begin
            req_ready = 1'b1;
        end
    endtask

    // hold the op until the stage takes it
    task automatic send_op(input mem_op_t op);
        in_valid = 1'b1;
        in_op    = op;
        while (!in_ready) begin
            next_cycle();
        end
        next_cycle();
        in_valid = 1'b0;
        in_op    = '0;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %s got %h exp %h (request %0d)", name, got, want, out_count);
            field_errors++;
        end
    endtask

    task automatic check_req(input cache_req_t got, input cache_req_t want);
        check_field("addr", got.addr, want.addr);
        check_field("wdata", got.wdata, want.wdata);
        check_field("write", 32'(got.write), 32'(want.write));
        check_field("wstrb", 32'(got.wstrb), 32'(want.wstrb));
        check_field("size", 32'(got.size), 32'(want.size));
        check_field("opcode", got.opcode, want.opcode);
        check_field("icache_op", 32'(got.icache_op), 32'(want.icache_op));
        check_field("dcache_op", 32'(got.dcache_op), 32'(want.dcache_op));
        check_field("l2_op", 32'(got.l2_op), 32'(want.l2_op));
        check_field("mmu_valid", 32'(got.mmu_valid), 32'(want.mmu_valid));
        check_field("ibar", 32'(got.ibar), 32'(want.ibar));
        check_field("ale", 32'(got.ale), 32'(want.ale));
    endtask

    // scoreboard, outputs first so a same-edge push never gets popped
    always @(posedge clk) begin
        if (!reset && req_valid && req_ready) begin
            if (expect_q.size() == 0) begin
                $display("request for address %h came out with no operation outstanding",
                         req.addr);
                flow_errors++;
            end else begin
                exp_req = expect_q.pop_front();
                check_req(req, exp_req);
            end
            out_count++;
        end
        if (!reset && in_valid && in_ready) begin
            expect_q.push_back(decode_ref(in_op));
            in_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped by timeout after %0d cycles, %0d of %0d requests seen",
                     cycle_count, out_count, TOTAL_OPS);
            $display("errors: %0d field, %0d flow", field_errors, flow_errors);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        mem_op_t op;
        int      cls;
        int      drain_wait;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_op     = '0;
        req_ready = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (req_valid !== 1'b0) begin
            $display("ERR req_valid got %h exp %h after reset", req_valid, 1'b0);
            field_errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("ERR in_ready got %h exp %h after reset", in_ready, 1'b1);
            field_errors++;
        end
        next_cycle();
        for (int i = 0; i < N_ALIGNED; i++) begin
            send_op(make_op(0, 5'(i % 8)));
        end
        for (int i = 0; i < N_MISALIGN; i++) begin
            send_op(make_op(1, 5'd0));
        end
        for (int i = 0; i < N_CACHE; i++) begin
            op = make_op(2, 5'd0);
            if (i < 8) begin
                op.ctrl[3:0]       = 4'd5; // every cacop target in turn
                op.ctrl[11:7]      = 5'd8;
                op.cacop_arg[2:0]  = 3'(i);
            end
            send_op(op);
        end
        for (int i = 0; i < N_ANY; i++) begin
            send_op(make_op(3, 5'd0));
        end
        ready_gaps = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            cls = int'(rand_bits(2));
            op  = make_op(cls, 5'(rand_bits(3)));
            send_op(op);
            if (rand_bits(2) == 32'd0) begin
                idle(int'(rand_bits(3)));
            end
        end
        ready_gaps = 1'b0;
        drain_wait = 0;
        while (expect_q.size() != 0 && drain_wait < 100) begin
            next_cycle();
            drain_wait++;
        end
        repeat (8) next_cycle(); // room for a stray request
        if (expect_q.size() != 0) begin
            $display("%0d operations never came out", expect_q.size());
            flow_errors++;
        end
        if (in_count != TOTAL_OPS || out_count != TOTAL_OPS) begin
            $display("sent %0d operations, stage took %0d and returned %0d",
                     TOTAL_OPS, in_count, out_count);
            flow_errors++;
        end
        $display("errors: %0d field, %0d flow", field_errors, flow_errors);
        if (field_errors == 0 && flow_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+hw
hw/mem_pkg.sv
hw/mem_issue.sv
hw/cache_ctr.sv
hw/mem_drain.sv
hw/mem_stage.sv
dv/mem_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the mem_stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module mem_stage_tb -o mem_stage_sim

if ! ./obj_dir/mem_stage_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
